// File: hdl/eth_frame_defs.svh
`ifndef ETH_FRAME_DEFS_SVH
`define ETH_FRAME_DEFS_SVH

// Sample words carried in every frame
`define EF_SAMPLES 8

// Buffer depths
`define EF_EVT_DEPTH 64
`define EF_L1A_DEPTH 16

// Almost-full margin on the sample buffer
`define EF_FLAG_MARGIN 4

// Fixed trailer words
`define EF_MARKER_WORD 16'h700C
`define EF_END_WORD 16'h7FFF

// Top nibble of the status word
`define EF_STATUS_TAG 4'h7

`endif

// File: hdl/eth_frame_pkg.sv
`default_nettype none

package eth_frame_pkg;

	typedef struct packed {
		logic phase;
		logic [23:0] num;
	} l1a_rec_t;

	typedef struct packed {
		logic ovlp;
		logic [11:0] data;
	} smp_rec_t;

	typedef struct packed {
		logic [2:0] zero;
		logic phase; // Only set in the high half
		logic [11:0] num;
	} trg_half_t;

	typedef struct packed {
		logic zero;
		logic novlp; // Inverted overlap flag
		logic [1:0] pad;
		logic [11:0] data;
	} smp_word_t;

	typedef union packed {
		trg_half_t trg;
		smp_word_t smp;
	} frame_word_u;

	// Frame order
	typedef enum logic [2:0] {
		HDR_HI,
		HDR_LO,
		SAMPLE,
		CRC,
		MARKER,
		STATUS,
		END
	} word_sel_e;

	// One 13-bit data step of the CRC-15, written as shifted copies of data and state
	function automatic logic [14:0] crc15_d13(input logic [12:0] d, input logic [14:0] c);
		logic [14:0] c_up;
		c_up = {1'b0, c[14:1]} & 15'h7ffe;
		return {2'b00, d} ^ {1'b0, d, 1'b0} ^ c_up ^ {c[1:0], c[14:2]};
	endfunction

endpackage

`default_nettype wire

// File: hdl/frame_step_if.sv
`timescale 1ns/1ps
`default_nettype none

interface frame_step_if;
	import eth_frame_pkg::*;

	logic step;
	word_sel_e sel;
	logic first; // HDR_HI step of a frame
	logic accept;

	modport seq (
		output step,
		output sel,
		output first,
		input accept
	);

	modport asm (
		input step,
		input sel,
		input first,
		output accept
	);

endinterface

`default_nettype wire

// File: hdl/event_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "eth_frame_defs.svh"

module event_fifo #(
	parameter int WIDTH = 13,
	parameter int DEPTH = 64,
	parameter int AFULL_MARGIN = 4
) (
	input wire RCLK,
	input wire RST_RESYNC,
	input wire push_i,
	input wire [WIDTH-1:0] din_i,
	output logic full_o,
	input wire pop_i,
	output logic [WIDTH-1:0] dout_o,
	output logic empty_o,
	output logic [$clog2(DEPTH):0] count_o,
	output logic amt_o,
	output logic afl_o
);
	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [AW:0] count_q;
	logic [AW:0] count_nxt;
	logic full_q;
	logic wr_en;
	logic rd_en;

	assign wr_en = push_i & ~full_q;
	assign rd_en = pop_i & ~empty_o;
	assign empty_o = (count_q == '0);
	assign full_o = full_q;
	assign dout_o = mem[rd_ptr_q]; // Show-ahead head
	assign count_o = count_q;
	assign amt_o = (count_q < (AW+1)'(`EF_SAMPLES));
	assign afl_o = (count_q >= (AW+1)'(DEPTH - AFULL_MARGIN));

	always_comb begin
		case ({wr_en, rd_en})
			2'b10: count_nxt = count_q + 1'b1;
			2'b01: count_nxt = count_q - 1'b1;
			default: count_nxt = count_q;
		endcase
	end

	always_ff @(posedge RCLK) begin
		if (wr_en)
			mem[wr_ptr_q] <= din_i;
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			full_q <= 1'b1; // Reads as full while in reset
		end else begin
			if (wr_en)
				wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (rd_en)
				rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			count_q <= count_nxt;
			full_q <= (count_nxt == (AW+1)'(DEPTH));
		end
	end

	a_no_pop_empty: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		pop_i |-> !empty_o);
	a_no_push_full: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		push_i |-> !full_o);

endmodule

`default_nettype wire

// File: hdl/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "eth_frame_defs.svh"

module frame_sequencer (
	input wire RCLK,
	input wire RST_RESYNC,
	frame_step_if.seq st,
	input wire l1a_empty_i,
	input wire smp_empty_i,
	input wire smp_amt_i,
	output logic l1a_pop_o,
	output logic smp_pop_o
);
	import eth_frame_pkg::*;

	localparam int CW = $clog2(`EF_SAMPLES + 1);

	logic run_q;
	word_sel_e sel_q;
	logic [CW-1:0] smp_cnt_q;
	logic frame_rdy;
	logic adv;
	logic last_smp;

	// Trigger waiting and enough samples for a whole frame
	assign frame_rdy = ~l1a_empty_i & ~smp_empty_i & ~smp_amt_i;

	assign st.step = run_q | frame_rdy;
	assign st.sel = sel_q;
	assign st.first = st.step & (sel_q == HDR_HI);

	assign adv = st.step & st.accept;
	assign last_smp = (smp_cnt_q == CW'(`EF_SAMPLES - 1));

	assign smp_pop_o = adv & (sel_q == SAMPLE);
	assign l1a_pop_o = adv & (sel_q == END); // Trigger leaves with the end word

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			run_q <= 1'b0;
			sel_q <= HDR_HI;
			smp_cnt_q <= '0;
		end else begin
			if (!run_q && frame_rdy)
				run_q <= 1'b1;
			else if (adv && sel_q == END)
				run_q <= 1'b0;

			if (adv) begin
				case (sel_q)
					HDR_HI: sel_q <= HDR_LO;
					HDR_LO: begin
						sel_q <= SAMPLE;
						smp_cnt_q <= '0;
					end
					SAMPLE: begin
						smp_cnt_q <= smp_cnt_q + 1'b1;
						if (last_smp)
							sel_q <= CRC;
					end
					CRC: sel_q <= MARKER;
					MARKER: sel_q <= STATUS;
					STATUS: sel_q <= END;
					default: sel_q <= HDR_HI; // END wraps to next frame
				endcase
			end
		end
	end

	// Buffer count was checked at frame start, so the samples must still be there
	a_smp_present: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		(st.step && st.sel == SAMPLE) |-> !smp_empty_i);

endmodule

`default_nettype wire

// File: hdl/frame_assembler.sv
`timescale 1ns/1ps
`default_nettype none
`include "eth_frame_defs.svh"

module frame_assembler (
	input wire RCLK,
	input wire RST_RESYNC,
	frame_step_if.asm st,
	input wire eth_frame_pkg::l1a_rec_t l1a_head_i,
	input wire eth_frame_pkg::smp_rec_t smp_head_i,
	input wire [4:0] l1a_count_i,
	input wire warn_i,
	output logic [15:0] txd_o,
	output logic txd_vld_o,
	input wire txd_rdy_i
);
	import eth_frame_pkg::*;

	logic [15:0] txd_q;
	logic vld_q;
	logic [14:0] crc_q;
	logic load;
	frame_word_u frm_word;

	// Register free now or emptied this cycle
	assign st.accept = ~vld_q | txd_rdy_i;
	assign load = st.step & st.accept;

	assign txd_o = txd_q;
	assign txd_vld_o = vld_q;

	always_comb begin
		frm_word = '0;
		case (st.sel)
			HDR_HI: begin
				frm_word.trg.phase = l1a_head_i.phase;
				frm_word.trg.num = l1a_head_i.num[23:12];
			end
			HDR_LO: frm_word.trg.num = l1a_head_i.num[11:0];
			SAMPLE: begin
				frm_word.smp.novlp = ~smp_head_i.ovlp;
				frm_word.smp.data = smp_head_i.data;
			end
			CRC: frm_word = {1'b0, crc_q};
			MARKER: frm_word = `EF_MARKER_WORD;
			STATUS: frm_word = {`EF_STATUS_TAG, l1a_head_i.num[5:0], l1a_count_i, warn_i};
			default: frm_word = `EF_END_WORD;
		endcase
	end

	// Restarts on every frame header
	always_ff @(posedge RCLK) begin
		if (load && st.first)
			crc_q <= '0;
		else if (load && st.sel == SAMPLE)
			crc_q <= crc15_d13({1'b0, smp_head_i.data}, crc_q);
	end

	always_ff @(posedge RCLK) begin
		if (load)
			txd_q <= frm_word;
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC)
			vld_q <= 1'b0;
		else if (load)
			vld_q <= 1'b1;
		else if (txd_rdy_i)
			vld_q <= 1'b0; // Word taken by the link
	end

	a_hold_stall: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		(txd_vld_o && !txd_rdy_i) |=> (txd_vld_o && $stable(txd_o)));

endmodule

`default_nettype wire

// File: hdl/eth_frame_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "eth_frame_defs.svh"

module eth_frame_top (
	input wire RCLK,
	input wire RST_RESYNC,
	input wire eth_frame_pkg::l1a_rec_t l1a_i,
	input wire l1a_vld_i,
	output logic l1a_rdy_o,
	input wire eth_frame_pkg::smp_rec_t smp_i,
	input wire smp_vld_i,
	output logic smp_rdy_o,
	input wire warn_i,
	output logic [15:0] txd_o,
	output logic txd_vld_o,
	input wire txd_rdy_i,
	output logic evt_buf_amt_o,
	output logic evt_buf_afl_o
);
	import eth_frame_pkg::*;

	l1a_rec_t l1a_head;
	smp_rec_t smp_head;
	logic l1a_full;
	logic l1a_empty;
	logic l1a_pop;
	logic [$clog2(`EF_L1A_DEPTH):0] l1a_count;
	logic smp_full;
	logic smp_empty;
	logic smp_pop;
	logic smp_amt;

	frame_step_if u_step ();

	assign l1a_rdy_o = ~l1a_full;
	assign smp_rdy_o = ~smp_full;
	assign evt_buf_amt_o = smp_amt;

	event_fifo #(
		.WIDTH($bits(l1a_rec_t)),
		.DEPTH(`EF_L1A_DEPTH),
		.AFULL_MARGIN(`EF_FLAG_MARGIN)
	) u_l1a_fifo (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.push_i(l1a_vld_i & l1a_rdy_o),
		.din_i(l1a_i),
		.full_o(l1a_full),
		.pop_i(l1a_pop),
		.dout_o(l1a_head),
		.empty_o(l1a_empty),
		.count_o(l1a_count),
		.amt_o(),
		.afl_o()
	);

	event_fifo #(
		.WIDTH($bits(smp_rec_t)),
		.DEPTH(`EF_EVT_DEPTH),
		.AFULL_MARGIN(`EF_FLAG_MARGIN)
	) u_smp_fifo (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.push_i(smp_vld_i & smp_rdy_o),
		.din_i(smp_i),
		.full_o(smp_full),
		.pop_i(smp_pop),
		.dout_o(smp_head),
		.empty_o(smp_empty),
		.count_o(),
		.amt_o(smp_amt),
		.afl_o(evt_buf_afl_o)
	);

	frame_sequencer u_seq (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.st(u_step.seq),
		.l1a_empty_i(l1a_empty),
		.smp_empty_i(smp_empty),
		.smp_amt_i(smp_amt),
		.l1a_pop_o(l1a_pop),
		.smp_pop_o(smp_pop)
	);

	frame_assembler u_asm (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.st(u_step.asm),
		.l1a_head_i(l1a_head),
		.smp_head_i(smp_head),
		.l1a_count_i(l1a_count),
		.warn_i(warn_i),
		.txd_o(txd_o),
		.txd_vld_o(txd_vld_o),
		.txd_rdy_i(txd_rdy_i)
	);

endmodule

`default_nettype wire

// File: sim/tb_eth_frame_tasks.svh
// Moves to 1 ns after the next rising edge
task automatic tick();
	@(posedge RCLK);
	#1;
endtask

task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAILED %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic end_test(input string name, input int err_before);
	tests_run++;
	$display("Test %s done with %0d errors", name, errors - err_before);
endtask

function automatic l1a_rec_t rand_l1a();
	l1a_rec_t t;
	t.phase = 1'($urandom);
	t.num = 24'($urandom);
	return t;
endfunction

function automatic smp_rec_t rand_smp();
	smp_rec_t s;
	s.ovlp = 1'($urandom);
	s.data = 12'($urandom);
	return s;
endfunction

function automatic string word_name(input int idx);
	case (idx)
		0: return "txd_o hdr_hi";
		1: return "txd_o hdr_lo";
		FRAME_WORDS - 4: return "txd_o crc";
		FRAME_WORDS - 3: return "txd_o marker";
		FRAME_WORDS - 2: return "txd_o status";
		FRAME_WORDS - 1: return "txd_o end";
		default: return "txd_o sample";
	endcase
endfunction

task automatic push_l1a(input l1a_rec_t rec);
	int waited;
	waited = 0;
	while (!l1a_rdy_o && waited < 100) begin
		tick();
		waited++;
	end
	if (!l1a_rdy_o) begin
		errors++;
		$display("Trigger input was not ready for %0d cycles", waited);
	end else begin
		l1a_i = rec;
		l1a_vld_i = 1'b1;
		tick(); // Taken on this edge
		l1a_vld_i = 1'b0;
		trig_q.push_back(rec);
	end
endtask

task automatic push_smp(input smp_rec_t rec);
	int waited;
	waited = 0;
	while (!smp_rdy_o && waited < 100) begin
		tick();
		waited++;
	end
	if (!smp_rdy_o) begin
		errors++;
		$display("Sample input was not ready for %0d cycles", waited);
	end else begin
		smp_i = rec;
		smp_vld_i = 1'b1;
		tick();
		smp_vld_i = 1'b0;
		smp_q.push_back(rec);
	end
endtask

task automatic push_samples(input int n);
	repeat (n) push_smp(rand_smp());
endtask

// All triggers go in first so the status counts are known
task automatic push_events(input int n);
	repeat (n) push_l1a(rand_l1a());
	push_samples(n * `EF_SAMPLES);
endtask

task automatic build_expected();
	l1a_rec_t t;
	smp_rec_t s;
	logic [14:0] crc;
	logic [4:0] cnt;
	cnt = 5'(trig_q.size()); // Current trigger still counted
	t = trig_q.pop_front();
	crc = '0;
	exp_q.push_back({3'b000, t.phase, t.num[23:12]});
	exp_q.push_back({4'h0, t.num[11:0]});
	repeat (`EF_SAMPLES) begin
		s = smp_q.pop_front();
		exp_q.push_back({1'b0, ~s.ovlp, 2'b00, s.data});
		crc = crc15_d13({1'b0, s.data}, crc);
	end
	exp_q.push_back({1'b0, crc});
	exp_q.push_back(`EF_MARKER_WORD);
	exp_q.push_back({`EF_STATUS_TAG, t.num[5:0], cnt, warn_i});
	exp_q.push_back(`EF_END_WORD);
endtask

task automatic collect_frames(input int n_frames, input bit rand_rdy);
	logic [15:0] held;
	bit stalled;
	int idx;
	int idle;
	exp_q.delete();
	repeat (n_frames) build_expected();
	idx = 0;
	idle = 0;
	stalled = 1'b0;
	held = '0;
	while (idx < n_frames * FRAME_WORDS) begin
		if (stalled) begin
			check_eq("txd_vld_o stalled", 16'(txd_vld_o), 16'h1);
			check_eq("txd_o stalled", txd_o, held);
		end
		txd_rdy_i = rand_rdy ? 1'($urandom) : 1'b1;
		if (txd_vld_o && txd_rdy_i) begin
			check_eq(word_name(idx % FRAME_WORDS), txd_o, exp_q.pop_front());
			idx++;
			idle = 0;
		end else begin
			idle++;
			if (idle > 200) begin
				errors++;
				$display("No output word for 200 cycles, %0d words still missing",
					n_frames * FRAME_WORDS - idx);
				break;
			end
		end
		stalled = txd_vld_o && !txd_rdy_i;
		held = txd_o;
		tick();
	end
	txd_rdy_i = 1'b0;
endtask

task automatic expect_quiet(input int cycles);
	txd_rdy_i = 1'b1;
	repeat (cycles) begin
		if (txd_vld_o) begin
			errors++;
			$display("Unexpected output word %h while no frame is due", txd_o);
			break;
		end
		tick();
	end
	txd_rdy_i = 1'b0;
endtask

task automatic test_idle_after_reset();
	int e0;
	e0 = errors;
	check_eq("txd_vld_o", 16'(txd_vld_o), 16'h0);
	check_eq("evt_buf_amt_o", 16'(evt_buf_amt_o), 16'h1);
	push_l1a(rand_l1a());
	push_samples(`EF_SAMPLES - 1);
	expect_quiet(30);
	push_samples(1); // Completes the event
	collect_frames(1, 1'b0);
	expect_quiet(10);
	end_test("idle after reset", e0);
endtask

task automatic test_single_event();
	int e0;
	int i;
	smp_rec_t s;
	e0 = errors;
	push_l1a('{phase: 1'b1, num: 24'hA53C7E});
	for (i = 0; i < `EF_SAMPLES; i++) begin
		s.ovlp = i[0];
		s.data = 12'(12'h100 * i + 12'h0F3);
		push_smp(s);
	end
	collect_frames(1, 1'b0);
	expect_quiet(20);
	end_test("single event", e0);
endtask

task automatic test_crc_random();
	int e0;
	e0 = errors;
	push_events(2);
	collect_frames(2, 1'b0);
	end_test("crc random", e0);
endtask

task automatic test_status_count();
	int e0;
	e0 = errors;
	warn_i = 1'b1;
	push_events(3);
	collect_frames(3, 1'b0);
	warn_i = 1'b0;
	end_test("status count", e0);
endtask

task automatic test_backpressure();
	int e0;
	e0 = errors;
	push_events(3);
	collect_frames(3, 1'b1);
	end_test("backpressure", e0);
endtask

task automatic test_buffer_flags();
	int e0;
	int i;
	e0 = errors;
	for (i = 1; i <= `EF_EVT_DEPTH; i++) begin
		push_smp(rand_smp());
		check_eq("evt_buf_afl_o", 16'(evt_buf_afl_o),
			16'(i >= `EF_EVT_DEPTH - `EF_FLAG_MARGIN));
		check_eq("evt_buf_amt_o", 16'(evt_buf_amt_o), 16'(i < `EF_SAMPLES));
	end
	check_eq("smp_rdy_o", 16'(smp_rdy_o), 16'h0); // Buffer full
	repeat (`EF_EVT_DEPTH / `EF_SAMPLES) push_l1a(rand_l1a());
	collect_frames(`EF_EVT_DEPTH / `EF_SAMPLES, 1'b0);
	check_eq("smp_rdy_o", 16'(smp_rdy_o), 16'h1);
	check_eq("evt_buf_afl_o", 16'(evt_buf_afl_o), 16'h0);
	check_eq("evt_buf_amt_o", 16'(evt_buf_amt_o), 16'h1);
	end_test("buffer flags", e0);
endtask

// File: sim/tb_eth_frame.sv
`timescale 1ns/1ps
`default_nettype none
`include "eth_frame_defs.svh"

module tb_eth_frame;
	import eth_frame_pkg::*;

	localparam int N_TESTS = 6;
	localparam int FRAME_WORDS = `EF_SAMPLES + 6;
	localparam int WATCHDOG_CYCLES = N_TESTS * 2000;

	logic RCLK;
	logic RST_RESYNC;
	l1a_rec_t l1a_i;
	logic l1a_vld_i;
	logic l1a_rdy_o;
	smp_rec_t smp_i;
	logic smp_vld_i;
	logic smp_rdy_o;
	logic warn_i;
	logic [15:0] txd_o;
	logic txd_vld_o;
	logic txd_rdy_i;
	logic evt_buf_amt_o;
	logic evt_buf_afl_o;

	// Records pushed but not yet framed
	l1a_rec_t trig_q[$];
	smp_rec_t smp_q[$];
	logic [15:0] exp_q[$]; // Expected words of the frames being collected

	int errors;
	int checks;
	int tests_run;

	eth_frame_top u_eth_frame_top (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.l1a_i(l1a_i),
		.l1a_vld_i(l1a_vld_i),
		.l1a_rdy_o(l1a_rdy_o),
		.smp_i(smp_i),
		.smp_vld_i(smp_vld_i),
		.smp_rdy_o(smp_rdy_o),
		.warn_i(warn_i),
		.txd_o(txd_o),
		.txd_vld_o(txd_vld_o),
		.txd_rdy_i(txd_rdy_i),
		.evt_buf_amt_o(evt_buf_amt_o),
		.evt_buf_afl_o(evt_buf_afl_o)
	);

	initial begin
		RCLK = 1'b0;
		forever #4 RCLK = ~RCLK; // 8 ns period
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge RCLK);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	`include "tb_eth_frame_tasks.svh"

	initial begin
		RST_RESYNC = 1'b1;
		l1a_i = '0;
		l1a_vld_i = 1'b0;
		smp_i = '0;
		smp_vld_i = 1'b0;
		warn_i = 1'b0;
		txd_rdy_i = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		void'($urandom(32'h12ad_6aad));
		repeat (10) @(posedge RCLK);
		#1;
		check_eq("txd_vld_o", 16'(txd_vld_o), 16'h0); // Still in reset
		check_eq("l1a_rdy_o", 16'(l1a_rdy_o), 16'h0);
		check_eq("smp_rdy_o", 16'(smp_rdy_o), 16'h0);
		RST_RESYNC = 1'b0;
		tick();

		test_idle_after_reset();
		test_single_event();
		test_crc_random();
		test_status_count();
		test_backpressure();
		test_buffer_flags();

		$display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hdl
+incdir+sim
hdl/eth_frame_pkg.sv
hdl/frame_step_if.sv
hdl/event_fifo.sv
hdl/frame_sequencer.sv
hdl/frame_assembler.sv
hdl/eth_frame_top.sv
sim/tb_eth_frame.sv

// File: Makefile
TOP := tb_eth_frame
SRCS := $(wildcard hdl/*.sv hdl/*.svh sim/*.sv sim/*.svh)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f $(SRCS)
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module eth_frame_top

clean:
	rm -rf obj_dir
